//--- uart_bus_config.svh
`ifndef UART_BUS_CONFIG_SVH
`define UART_BUS_CONFIG_SVH

// bits per data word on both the write and the read path
`define UB_DATA_WIDTH 32

// width of the slave id field in a command frame
`define UB_ID_WIDTH 3

// id this slave answers to
`define UB_SLAVE_ID 3'd1

// leading code of every command frame
`define UB_START_CODE 3'b111

// command frame length, msb first:
// start code (3) | slave id (3) | write (1) | burst (1)
`define UB_FRAME_BITS 8

`endif

//--- uart_bus_pkg.sv
`include "uart_bus_config.svh"

package uart_bus_pkg;

    // serial signals from the bus master
    typedef struct packed {
        // command frame, one bit per cycle
        logic control;
        // write data bit
        logic wd;
        // wd holds a valid bit
        logic valid;
        // marks the final word of a burst
        logic last;
    } bus_in_t;

    // serial signals back to the bus master
    typedef struct packed {
        // read data bit
        logic rd;
        // rd holds a valid bit
        logic rd_valid;
        // high while no session is running
        logic ready;
    } bus_out_t;

    // command decoded from an addressed frame
    typedef struct packed {
        // 1 = master writes towards the transmitter
        logic write;
        logic burst;
    } cmd_t;

    // one data word exchanged with the UART blocks
    typedef logic [`UB_DATA_WIDTH-1:0] word_t;

endpackage

//--- ctrl_frame_decoder.sv
`include "uart_bus_config.svh"

module ctrl_frame_decoder (
    input  logic               clk,
    input  logic               rstN,
    input  logic               idle,
    input  logic               control,
    output logic               cmd_valid,
    output uart_bus_pkg::cmd_t cmd
);

    localparam int unsigned CNT_W   = $clog2(`UB_FRAME_BITS);
    localparam int unsigned CODE_W  = 3;
    // field positions inside the frame, msb arrives first
    localparam int unsigned CODE_HI = `UB_FRAME_BITS - 1;
    localparam int unsigned ID_HI   = `UB_FRAME_BITS - 1 - CODE_W;

    logic                      receiving;
    logic [CNT_W-1:0]          bit_cnt;
    logic [`UB_FRAME_BITS-1:0] shift_q;
    logic [`UB_FRAME_BITS-1:0] frame;
    logic                      take_bit;
    logic                      last_bit;
    logic                      match;

    // a frame can only open between sessions, and its first bit is always high
    assign take_bit = receiving || (idle && control);

    // frame contents including the bit on control this cycle
    assign frame    = {shift_q[`UB_FRAME_BITS-2:0], control};
    assign last_bit = receiving && (bit_cnt == CNT_W'(`UB_FRAME_BITS - 1));

    assign match = (frame[CODE_HI -: CODE_W] == `UB_START_CODE) &&
                   (frame[ID_HI -: `UB_ID_WIDTH] == `UB_SLAVE_ID);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            receiving <= 1'b0;
            bit_cnt   <= '0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            if (last_bit) begin
                // frames for other slaves or with a bad code are dropped here
                receiving <= 1'b0;
                bit_cnt   <= '0;
                cmd_valid <= match;
            end else if (take_bit) begin
                receiving <= 1'b1;
                bit_cnt   <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_bit) begin
            shift_q <= frame;
        end
        if (last_bit) begin
            cmd.write <= frame[1];
            cmd.burst <= frame[0];
        end
    end

endmodule

//--- write_deserializer.sv
`include "uart_bus_config.svh"

module write_deserializer (
    input  logic                clk,
    input  logic                rstN,
    input  logic                start,
    input  logic                burst,
    input  logic                wd,
    input  logic                valid,
    input  logic                last,
    output logic                tx_req,
    input  logic                tx_ack,
    output uart_bus_pkg::word_t tx_word,
    output logic                done
);

    localparam int unsigned W     = `UB_DATA_WIDTH;
    localparam int unsigned CNT_W = $clog2(W);

    typedef enum logic [1:0] {
        W_IDLE,
        W_SHIFT,
        W_REQ,
        W_RELEASE
    } wstate_e;

    wstate_e             state;
    logic [CNT_W-1:0]    bit_cnt;
    logic                burst_q;
    logic                last_q;
    uart_bus_pkg::word_t shift_q;
    logic                take_bit;
    logic                word_full;

    // valid is ignored outside W_SHIFT, so the master must hold its bit
    assign take_bit  = (state == W_SHIFT) && valid;
    assign word_full = take_bit && (bit_cnt == CNT_W'(W - 1));

    // no bits are taken during the handshake so the word stays stable
    assign tx_word = shift_q;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= W_IDLE;
            bit_cnt <= '0;
            burst_q <= 1'b0;
            last_q  <= 1'b0;
            tx_req  <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                W_IDLE: begin
                    if (start) begin
                        burst_q <= burst;
                        bit_cnt <= '0;
                        state   <= W_SHIFT;
                    end
                end
                W_SHIFT: begin
                    if (word_full) begin
                        // last on the final bit decides whether the burst goes on
                        bit_cnt <= '0;
                        last_q  <= last;
                        tx_req  <= 1'b1;
                        state   <= W_REQ;
                    end else if (take_bit) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                W_REQ: begin
                    if (tx_ack) begin
                        tx_req <= 1'b0;
                        state  <= W_RELEASE;
                    end
                end
                W_RELEASE: begin
                    // wait for ack low before the next word may be requested
                    if (!tx_ack) begin
                        if (burst_q && !last_q) begin
                            state <= W_SHIFT;
                        end else begin
                            done  <= 1'b1;
                            state <= W_IDLE;
                        end
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_bit) begin
            shift_q <= {shift_q[W-2:0], wd};
        end
    end

endmodule

//--- read_serializer.sv
`include "uart_bus_config.svh"

module read_serializer (
    input  logic                clk,
    input  logic                rstN,
    input  logic                start,
    input  logic                burst,
    input  logic                last,
    output logic                rx_req,
    input  logic                rx_ack,
    input  uart_bus_pkg::word_t rx_word,
    output logic                rd,
    output logic                rd_valid,
    output logic                done
);

    localparam int unsigned W     = `UB_DATA_WIDTH;
    localparam int unsigned CNT_W = $clog2(W);

    typedef enum logic [1:0] {
        R_IDLE,
        R_REQ,
        R_RELEASE,
        R_SHIFT
    } rstate_e;

    rstate_e             state;
    logic [CNT_W-1:0]    bit_cnt;
    logic                burst_q;
    uart_bus_pkg::word_t shift_q;
    logic                load;
    logic                final_bit;

    // word is captured on the cycle ack is seen high
    assign load      = (state == R_REQ) && rx_ack;
    assign rd_valid  = (state == R_SHIFT);
    assign final_bit = rd_valid && (bit_cnt == CNT_W'(W - 1));

    // msb of the shift register goes out, forced low between words
    assign rd = rd_valid && shift_q[W-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= R_IDLE;
            bit_cnt <= '0;
            burst_q <= 1'b0;
            rx_req  <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (start) begin
                        burst_q <= burst;
                        rx_req  <= 1'b1;
                        state   <= R_REQ;
                    end
                end
                R_REQ: begin
                    if (load) begin
                        rx_req <= 1'b0;
                        state  <= R_RELEASE;
                    end
                end
                R_RELEASE: begin
                    if (!rx_ack) begin
                        bit_cnt <= '0;
                        state   <= R_SHIFT;
                    end
                end
                R_SHIFT: begin
                    if (final_bit) begin
                        bit_cnt <= '0;
                        // same rule as writes: last on the final bit ends the burst
                        if (burst_q && !last) begin
                            rx_req <= 1'b1;
                            state  <= R_REQ;
                        end else begin
                            done  <= 1'b1;
                            state <= R_IDLE;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= rx_word;
        end else if (rd_valid) begin
            shift_q <= {shift_q[W-2:0], 1'b0};
        end
    end

endmodule

//--- uart_bus_slave.sv
module uart_bus_slave (
    input  logic                   clk,
    input  logic                   rstN,
    input  uart_bus_pkg::bus_in_t  bus_in,
    output uart_bus_pkg::bus_out_t bus_out,
    output logic                   tx_req,
    input  logic                   tx_ack,
    output uart_bus_pkg::word_t    tx_word,
    output logic                   rx_req,
    input  logic                   rx_ack,
    input  uart_bus_pkg::word_t    rx_word
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITE,
        S_READ
    } session_e;

    session_e           state;
    logic               idle;
    logic               cmd_valid;
    uart_bus_pkg::cmd_t cmd;
    logic               wr_start;
    logic               rd_start;
    logic               wr_done;
    logic               rd_done;
    logic               rd_bit;
    logic               rd_bit_valid;

    assign idle = (state == S_IDLE);

    // a decoded command starts exactly one data path
    assign wr_start = idle && cmd_valid && cmd.write;
    assign rd_start = idle && cmd_valid && !cmd.write;

    // session FSM, ready follows the state one cycle after cmd_valid and done
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cmd_valid) begin
                        state <= cmd.write ? S_WRITE : S_READ;
                    end
                end
                S_WRITE: begin
                    if (wr_done) begin
                        state <= S_IDLE;
                    end
                end
                S_READ: begin
                    if (rd_done) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign bus_out.rd       = rd_bit;
    assign bus_out.rd_valid = rd_bit_valid;
    assign bus_out.ready    = idle;

    ctrl_frame_decoder u_decoder (
        .clk       (clk),
        .rstN      (rstN),
        .idle      (idle),
        .control   (bus_in.control),
        .cmd_valid (cmd_valid),
        .cmd       (cmd)
    );

    write_deserializer u_writer (
        .clk     (clk),
        .rstN    (rstN),
        .start   (wr_start),
        .burst   (cmd.burst),
        .wd      (bus_in.wd),
        .valid   (bus_in.valid),
        .last    (bus_in.last),
        .tx_req  (tx_req),
        .tx_ack  (tx_ack),
        .tx_word (tx_word),
        .done    (wr_done)
    );

    read_serializer u_reader (
        .clk      (clk),
        .rstN     (rstN),
        .start    (rd_start),
        .burst    (cmd.burst),
        .last     (bus_in.last),
        .rx_req   (rx_req),
        .rx_ack   (rx_ack),
        .rx_word  (rx_word),
        .rd       (rd_bit),
        .rd_valid (rd_bit_valid),
        .done     (rd_done)
    );

endmodule

//--- uart_bus_slave_assert.sv
`include "uart_bus_config.svh"

module uart_bus_slave_assert (
    input logic                   clk,
    input logic                   rstN,
    input uart_bus_pkg::bus_in_t  bus_in,
    input uart_bus_pkg::bus_out_t bus_out,
    input logic                   tx_req,
    input logic                   tx_ack,
    input uart_bus_pkg::word_t    tx_word,
    input logic                   rx_req,
    input logic                   rx_ack,
    input uart_bus_pkg::word_t    rx_word
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned W = `UB_DATA_WIDTH;

    uart_bus_pkg::word_t exp_tx;
    uart_bus_pkg::word_t rx_ref;
    int unsigned         rd_idx;
    logic                ack_q;
    logic                take;
    int unsigned         fail_cnt = 0;

    // bits are held off while a transmitter handshake is open
    assign take = bus_in.valid && !bus_out.ready && !tx_req && !tx_ack && !ack_q;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exp_tx <= '0;
            rx_ref <= '0;
            rd_idx <= 0;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= tx_ack;
            if (take) begin
                exp_tx <= {exp_tx[W-2:0], bus_in.wd};
            end
            if (rx_req && rx_ack) begin
                rx_ref <= rx_word;
                rd_idx <= W - 1;
            end else if (bus_out.rd_valid) begin
                rd_idx <= rd_idx - 1;
            end
        end
    end

    reset_values: assert property (@(posedge clk)
        !rstN |-> bus_out.ready && !tx_req && !rx_req && !bus_out.rd_valid)
        else begin
            $error("outputs not at reset values during reset");
            fail_cnt++;
        end

    tx_req_holds: assert property (@(posedge clk) disable iff (!rstN)
        tx_req && !tx_ack |=> tx_req)
        else begin
            $error("tx_req dropped before tx_ack");
            fail_cnt++;
        end
    tx_req_rise: assert property (@(posedge clk) disable iff (!rstN)
        $rose(tx_req) |-> !tx_ack)
        else begin
            $error("tx_req rose while tx_ack still high");
            fail_cnt++;
        end
    tx_word_stable: assert property (@(posedge clk) disable iff (!rstN)
        tx_req && $past(tx_req) |-> $stable(tx_word))
        else begin
            $error("tx_word changed during handshake");
            fail_cnt++;
        end
    tx_word_value: assert property (@(posedge clk) disable iff (!rstN)
        $rose(tx_req) |-> tx_word == exp_tx)
        else begin
            $error("tx_word differs from the bits sent on wd");
            fail_cnt++;
        end

    rx_req_holds: assert property (@(posedge clk) disable iff (!rstN)
        rx_req && !rx_ack |=> rx_req)
        else begin
            $error("rx_req dropped before rx_ack");
            fail_cnt++;
        end
    rx_req_rise: assert property (@(posedge clk) disable iff (!rstN)
        $rose(rx_req) |-> !rx_ack)
        else begin
            $error("rx_req rose while rx_ack still high");
            fail_cnt++;
        end
    rd_value: assert property (@(posedge clk) disable iff (!rstN)
        bus_out.rd_valid |-> bus_out.rd == rx_ref[rd_idx])
        else begin
            $error("rd bit differs from the received word");
            fail_cnt++;
        end

endmodule

//--- tb_uart_bus_slave.sv
`include "uart_bus_config.svh"

module tb_uart_bus_slave;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned W       = `UB_DATA_WIDTH;
    localparam int unsigned N_TESTS = 6;
    localparam int unsigned LIMIT   = N_TESTS * 4 * (W + `UB_FRAME_BITS + 20);

    logic                   clk;
    logic                   rstN;
    uart_bus_pkg::bus_in_t  bus_in;
    uart_bus_pkg::bus_out_t bus_out;
    logic                   tx_req;
    logic                   tx_ack;
    uart_bus_pkg::word_t    tx_word;
    logic                   rx_req;
    logic                   rx_ack;
    uart_bus_pkg::word_t    rx_word;

    logic [15:0]         lfsr = 16'd2681;
    uart_bus_pkg::word_t sent_q[$];
    uart_bus_pkg::word_t tx_got_q[$];
    uart_bus_pkg::word_t rx_sent_q[$];
    uart_bus_pkg::word_t rd_got_q[$];
    int unsigned         errors;
    int unsigned         failed;
    int unsigned         tests;
    int unsigned         err_at_start;

    uart_bus_slave uut (.*);

    bind uart_bus_slave uart_bus_slave_assert u_assert (.*);

    always #10 clk = ~clk;

    // taps 16 14 13 11
    function automatic logic next_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic uart_bus_pkg::word_t next_word();
        uart_bus_pkg::word_t w;
        for (int i = W - 1; i >= 0; i--) begin
            w[i] = next_bit();
        end
        return w;
    endfunction

    // procedural errors plus failed properties of the bound checker
    function automatic int unsigned error_total();
        return errors + uut.u_assert.fail_cnt;
    endfunction

    // transmitter side, ack after a short random delay
    initial begin
        forever begin
            @(posedge clk);
            if (tx_req && !tx_ack) begin
                tx_got_q.push_back(tx_word);
                repeat ({next_bit(), next_bit()}) @(posedge clk);
                @(negedge clk);
                tx_ack = 1'b1;
                do @(posedge clk); while (tx_req);
                @(negedge clk);
                tx_ack = 1'b0;
            end
        end
    end

    // receiver side, a fresh word with every ack
    initial begin
        forever begin
            @(posedge clk);
            if (rx_req && !rx_ack) begin
                repeat ({next_bit(), next_bit()}) @(posedge clk);
                @(negedge clk);
                rx_word = next_word();
                rx_ack  = 1'b1;
                rx_sent_q.push_back(rx_word);
                do @(posedge clk); while (rx_req);
                @(negedge clk);
                rx_ack = 1'b0;
            end
        end
    end

    task automatic check_word(input string name, input uart_bus_pkg::word_t exp,
                              input uart_bus_pkg::word_t act);
        assert (exp === act) else begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int unsigned exp,
                               input int unsigned act);
        assert (exp == act) else begin
            $display("Mismatch %s: expected %0d words, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic wait_ready(input logic level);
        do @(posedge clk); while (bus_out.ready !== level);
    endtask

    task automatic send_frame(input logic [2:0] id, input logic wr, input logic burst);
        logic [7:0] f;
        f = {`UB_START_CODE, id, wr, burst};
        for (int i = 7; i >= 0; i--) begin
            @(negedge clk);
            bus_in.control = f[i];
        end
        @(negedge clk);
        bus_in.control = 1'b0;
    endtask

    // one word msb first, then waits until the handshake has closed
    task automatic write_word(input logic is_last, input logic gaps, input logic hold);
        uart_bus_pkg::word_t w;
        for (int i = W - 1; i >= 0; i--) begin
            w[i] = next_bit();
            if (gaps && i == W / 2) begin
                @(negedge clk);
                bus_in.valid = 1'b0;
            end
            @(negedge clk);
            bus_in.wd    = w[i];
            bus_in.valid = 1'b1;
            bus_in.last  = is_last && (i == 0);
        end
        sent_q.push_back(w);
        @(negedge clk);
        bus_in.last = 1'b0;
        if (!hold) begin
            bus_in.valid = 1'b0;
        end
        do @(posedge clk); while (!tx_ack);
        do @(posedge clk); while (tx_ack);
    endtask

    task automatic read_words(input int unsigned n);
        uart_bus_pkg::word_t w;
        int unsigned         cnt;
        for (int unsigned k = 0; k < n; k++) begin
            cnt = 0;
            while (cnt < W) begin
                @(posedge clk);
                if (bus_out.rd_valid) begin
                    w = {w[W-2:0], bus_out.rd};
                    cnt++;
                    if (cnt == W - 1) begin
                        @(negedge clk);
                        bus_in.last = (k == n - 1);
                    end
                end
            end
            rd_got_q.push_back(w);
            @(negedge clk);
            bus_in.last = 1'b0;
        end
    endtask

    task automatic compare_queues(input string name, input uart_bus_pkg::word_t exp_q[$],
                                  input uart_bus_pkg::word_t act_q[$]);
        check_count(name, exp_q.size(), act_q.size());
        for (int i = 0; i < exp_q.size() && i < act_q.size(); i++) begin
            check_word(name, exp_q[i], act_q[i]);
        end
    endtask

    task automatic begin_test();
        err_at_start = error_total();
        sent_q.delete();
        tx_got_q.delete();
        rx_sent_q.delete();
        rd_got_q.delete();
    endtask

    task automatic end_test(input string name);
        tests++;
        if (error_total() == err_at_start) begin
            $display("test %s passed", name);
        end else begin
            failed++;
            $display("test %s failed", name);
        end
    endtask

    initial begin
        #(LIMIT * 20);
        $display("timeout: the tests did not finish within %0d cycles", LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk     = 1'b0;
        rstN    = 1'b0;
        bus_in  = '0;
        tx_ack  = 1'b0;
        rx_ack  = 1'b0;
        rx_word = '0;
        errors  = 0;
        failed  = 0;
        tests   = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        begin_test();
        @(posedge clk);
        assert (bus_out.ready && !tx_req && !rx_req && !bus_out.rd_valid) else begin
            $display("reset_state: outputs are not at their reset values");
            errors++;
        end
        end_test("reset_state");

        begin_test();
        send_frame(3'd2, 1'b1, 1'b0);
        repeat (20) begin
            @(posedge clk);
            assert (bus_out.ready && !tx_req && !rx_req) else begin
                $display("wrong_id: slave answered a frame for another id");
                errors++;
            end
        end
        end_test("wrong_id");

        begin_test();
        send_frame(`UB_SLAVE_ID, 1'b1, 1'b0);
        wait_ready(1'b0);
        write_word(1'b0, 1'b1, 1'b0);
        wait_ready(1'b1);
        compare_queues("single_write", sent_q, tx_got_q);
        end_test("single_write");

        begin_test();
        send_frame(`UB_SLAVE_ID, 1'b1, 1'b1);
        wait_ready(1'b0);
        write_word(1'b0, 1'b0, 1'b1);
        write_word(1'b0, 1'b0, 1'b1);
        write_word(1'b1, 1'b0, 1'b0);
        wait_ready(1'b1);
        compare_queues("write_burst", sent_q, tx_got_q);
        end_test("write_burst");

        begin_test();
        send_frame(`UB_SLAVE_ID, 1'b0, 1'b0);
        wait_ready(1'b0);
        read_words(1);
        wait_ready(1'b1);
        compare_queues("single_read", rx_sent_q, rd_got_q);
        end_test("single_read");

        begin_test();
        send_frame(`UB_SLAVE_ID, 1'b0, 1'b1);
        wait_ready(1'b0);
        read_words(3);
        wait_ready(1'b1);
        repeat (5) @(posedge clk);
        compare_queues("read_burst", rx_sent_q, rd_got_q);
        end_test("read_burst");

        $display("%0d tests run, %0d failed, %0d errors", tests, failed, error_total());
        if (error_total() == 0 && tests == N_TESTS) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+.
uart_bus_pkg.sv
ctrl_frame_decoder.sv
write_deserializer.sv
read_serializer.sv
uart_bus_slave.sv
uart_bus_slave_assert.sv
tb_uart_bus_slave.sv

//--- Bender.yml
package:
  name: uart_bus_slave

sources:
  - include_dirs:
      - .
    files:
      - uart_bus_pkg.sv
      - ctrl_frame_decoder.sv
      - write_deserializer.sv
      - read_serializer.sv
      - uart_bus_slave.sv
  - target: test
    include_dirs:
      - .
    files:
      - uart_bus_slave_assert.sv
      - tb_uart_bus_slave.sv
